/* common/eeprom_pkg.sv */
package eeprom_pkg;

    // CLK cycles per quarter of an SCL period, one bus bit is four quarters
    localparam int SCL_QUARTER = 5;
    localparam int QUARTER_W   = $clog2(SCL_QUARTER + 1);

    localparam logic [3:0] DEVICE_CODE = 4'b1010;  // control byte prefix

    // quarters of a bus bit as seen by the byte engine
    localparam logic [1:0] PHASE_SETUP  = 2'd0;  // scl low, sda may change
    localparam logic [1:0] PHASE_SAMPLE = 2'd2;  // scl high, sda sampled

    typedef logic [10:0]          eeprom_addr_t;  // 2 KB device
    typedef logic [7:0]           byte_t;
    typedef logic [QUARTER_W-1:0] quarter_cnt_t;

    // host level sequencer
    typedef enum logic [3:0] {
        seq_idle,
        seq_start_write,
        seq_ctrl_write,
        seq_addr_write,
        seq_data_write,
        seq_restart,
        seq_ctrl_read,
        seq_data_read,
        seq_stop,
        seq_finish
    } seq_state_t;

    // one bus command at a time
    typedef enum logic [2:0] {
        bit_idle,
        bit_start,
        bit_stop,
        bit_shift,
        bit_ack,
        bit_done
    } bit_state_t;

endpackage

/* logic/scl_timer.sv */
`timescale 1ns/1ns

module scl_timer
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       bus_active,
    output logic       quarter_tick,
    output logic [1:0] phase,
    output logic       scl
);
    import eeprom_pkg::*;

    quarter_cnt_t cnt;

    // wrap of the quarter counter
    assign quarter_tick = bus_active && (cnt == quarter_cnt_t'(SCL_QUARTER - 1));

    // low in quarters 0 and 3, released when the bus is idle
    assign scl = !bus_active || (phase == 2'd1) || (phase == 2'd2);

    always_ff @(posedge CLK)
    begin
        if (RESET || !bus_active)
        begin
            cnt   <= '0;
            phase <= 2'd0;  // every activation starts at the low quarter
        end
        else if (quarter_tick)
        begin
            cnt   <= '0;
            phase <= phase + 2'd1;
        end
        else
        begin
            cnt <= cnt + quarter_cnt_t'(1);
        end
    end

endmodule

/* i2c_master/i2c_byte_engine.sv */
`timescale 1ns/1ns

module i2c_byte_engine
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_start,
    input  logic              cmd_stop,
    input  logic              cmd_write,
    input  logic              cmd_read,
    input  eeprom_pkg::byte_t tx_byte,
    input  logic              master_nack,
    input  logic              quarter_tick,
    input  logic [1:0]        phase,
    input  logic              sda_in,
    output logic              bus_active,
    output logic              sda_low,
    output logic              cmd_done,
    output eeprom_pkg::byte_t rx_byte,
    output logic              slave_ack
);
    import eeprom_pkg::*;

    bit_state_t state;
    byte_t      shreg;
    logic [2:0] bit_cnt;
    logic       is_read;
    logic       step;   // first CLK of a new quarter
    logic       armed;  // current bit has had its setup quarter
    logic       setup_step;
    logic       sample_step;

    // acting one CLK into the quarter keeps sda edges clear of scl edges
    assign setup_step  = step && (phase == PHASE_SETUP);
    assign sample_step = step && (phase == PHASE_SAMPLE);

    assign cmd_done = (state == bit_done);
    assign rx_byte  = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= bit_idle;
            bus_active <= 1'b0;
            sda_low    <= 1'b0;
            step       <= 1'b0;
            armed      <= 1'b0;
            slave_ack  <= 1'b0;
        end
        else
        begin
            step <= quarter_tick;

            case (state)
                bit_idle:
                begin
                    armed <= 1'b0;
                    if (cmd_start)
                    begin
                        bus_active <= 1'b1;  // timer runs until the stop
                        state      <= bit_start;
                    end
                    else if (cmd_stop)
                    begin
                        state <= bit_stop;
                    end
                    else if (cmd_write || cmd_read)
                    begin
                        shreg   <= tx_byte;
                        is_read <= cmd_read;
                        bit_cnt <= 3'd0;
                        state   <= bit_shift;
                    end
                end

                bit_start:
                begin
                    if (setup_step)
                        sda_low <= 1'b0;  // repeated start, release first
                    else if (sample_step)
                    begin
                        sda_low <= 1'b1;  // sda falls while scl high
                        state   <= bit_done;
                    end
                end

                bit_stop:
                begin
                    if (setup_step)
                    begin
                        sda_low <= 1'b1;
                        armed   <= 1'b1;
                    end
                    else if (sample_step && armed)
                    begin
                        sda_low    <= 1'b0;  // sda rises while scl high
                        bus_active <= 1'b0;
                        state      <= bit_done;
                    end
                end

                bit_shift:
                begin
                    if (setup_step)
                    begin
                        sda_low <= !is_read && !shreg[7];  // msb first
                        armed   <= 1'b1;
                    end
                    else if (sample_step && armed)
                    begin
                        shreg   <= {shreg[6:0], is_read ? sda_in : 1'b0};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= bit_ack;
                    end
                end

                bit_ack:
                begin
                    if (setup_step)
                        sda_low <= is_read && !master_nack;  // ninth bit
                    else if (sample_step)
                    begin
                        if (!is_read)
                            slave_ack <= !sda_in;
                        state <= bit_done;
                    end
                end

                bit_done:
                    state <= bit_idle;

                default:
                    state <= bit_idle;
            endcase
        end
    end

endmodule

/* i2c_master/eeprom_sequencer.sv */
`timescale 1ns/1ns

module eeprom_sequencer
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::byte_t        wdata,
    input  logic                     cmd_done,
    input  eeprom_pkg::byte_t        rx_byte,
    input  logic                     slave_ack,
    output logic                     cmd_start,
    output logic                     cmd_stop,
    output logic                     cmd_write,
    output logic                     cmd_read,
    output eeprom_pkg::byte_t        tx_byte,
    output logic                     master_nack,
    output logic                     busy,
    output logic                     done,
    output logic                     ack_error,
    output eeprom_pkg::byte_t        rdata
);
    import eeprom_pkg::*;

    seq_state_t   state;
    eeprom_addr_t addr_q;
    byte_t        wdata_q;
    byte_t        ctrl_byte;
    logic         is_read;
    logic         issued;      // command out, waiting for cmd_done
    logic         write_state; // states that send a byte and expect an ack

    assign busy = (state != seq_idle);
    assign done = (state == seq_finish);

    // block bits from addr[10:8], r/w bit last
    assign ctrl_byte = {DEVICE_CODE, addr_q[10:8], state == seq_ctrl_read};

    assign write_state = (state == seq_ctrl_write) || (state == seq_addr_write) ||
                         (state == seq_data_write) || (state == seq_ctrl_read);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= seq_idle;
            issued      <= 1'b0;
            cmd_start   <= 1'b0;
            cmd_stop    <= 1'b0;
            cmd_write   <= 1'b0;
            cmd_read    <= 1'b0;
            master_nack <= 1'b0;
            ack_error   <= 1'b0;
        end
        else
        begin
            cmd_start <= 1'b0;
            cmd_stop  <= 1'b0;
            cmd_write <= 1'b0;
            cmd_read  <= 1'b0;

            if (state == seq_idle)
            begin
                if (wr || rd)  // wr wins on a tie
                begin
                    addr_q    <= addr;
                    wdata_q   <= wdata;
                    is_read   <= !wr;
                    ack_error <= 1'b0;
                    state     <= seq_start_write;
                end
            end
            else if (state == seq_finish)
            begin
                state <= seq_idle;
            end
            else if (!issued)
            begin
                issued <= 1'b1;
                case (state)
                    seq_start_write, seq_restart:
                        cmd_start <= 1'b1;
                    seq_ctrl_write, seq_ctrl_read:
                    begin
                        cmd_write <= 1'b1;
                        tx_byte   <= ctrl_byte;
                    end
                    seq_addr_write:
                    begin
                        cmd_write <= 1'b1;
                        tx_byte   <= addr_q[7:0];
                    end
                    seq_data_write:
                    begin
                        cmd_write <= 1'b1;
                        tx_byte   <= wdata_q;
                    end
                    seq_data_read:
                    begin
                        cmd_read    <= 1'b1;
                        master_nack <= 1'b1;  // single byte read ends with nack
                    end
                    default:
                        cmd_stop <= 1'b1;
                endcase
            end
            else if (cmd_done)
            begin
                issued <= 1'b0;
                if (write_state && !slave_ack)
                begin
                    ack_error <= 1'b1;
                    state     <= seq_stop;  // drop the rest of the bytes
                end
                else
                begin
                    case (state)
                        seq_start_write: state <= seq_ctrl_write;
                        seq_ctrl_write:  state <= seq_addr_write;
                        seq_addr_write:  state <= is_read ? seq_restart : seq_data_write;
                        seq_data_write:  state <= seq_stop;
                        seq_restart:     state <= seq_ctrl_read;
                        seq_ctrl_read:   state <= seq_data_read;
                        seq_data_read:
                        begin
                            rdata <= rx_byte;
                            state <= seq_stop;
                        end
                        default:         state <= seq_finish;
                    endcase
                end
            end
        end
    end

endmodule

/* logic/eeprom_ctrl_top.sv */
`timescale 1ns/1ns

module eeprom_ctrl_top
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::byte_t        wdata,
    input  logic                     sda_in,
    output eeprom_pkg::byte_t        rdata,
    output logic                     busy,
    output logic                     done,
    output logic                     ack_error,
    output logic                     scl,
    output logic                     sda_low
);
    import eeprom_pkg::*;

    logic       bus_active;
    logic       quarter_tick;
    logic [1:0] phase;
    logic       cmd_start;
    logic       cmd_stop;
    logic       cmd_write;
    logic       cmd_read;
    logic       cmd_done;
    logic       master_nack;
    logic       slave_ack;
    byte_t      tx_byte;
    byte_t      rx_byte;

    scl_timer u_timer
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .bus_active   (bus_active),
        .quarter_tick (quarter_tick),
        .phase        (phase),
        .scl          (scl)
    );

    i2c_byte_engine u_engine
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmd_start    (cmd_start),
        .cmd_stop     (cmd_stop),
        .cmd_write    (cmd_write),
        .cmd_read     (cmd_read),
        .tx_byte      (tx_byte),
        .master_nack  (master_nack),
        .quarter_tick (quarter_tick),
        .phase        (phase),
        .sda_in       (sda_in),
        .bus_active   (bus_active),
        .sda_low      (sda_low),
        .cmd_done     (cmd_done),
        .rx_byte      (rx_byte),
        .slave_ack    (slave_ack)
    );

    eeprom_sequencer u_seq
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .slave_ack   (slave_ack),
        .cmd_start   (cmd_start),
        .cmd_stop    (cmd_stop),
        .cmd_write   (cmd_write),
        .cmd_read    (cmd_read),
        .tx_byte     (tx_byte),
        .master_nack (master_nack),
        .busy        (busy),
        .done        (done),
        .ack_error   (ack_error),
        .rdata       (rdata)
    );

endmodule

/* tests/eeprom_model.sv */
`timescale 1ns/1ns

module eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic enable,
    output logic sda_release
);
    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg;
    logic [2:0]  block;
    logic [10:0] ptr;
    logic        drive_low;
    logic        active;
    logic        sending;
    logic        go_send;  // control byte asked for a read
    logic        acked;
    int          bit_cnt;
    int          byte_idx;
    logic        scl_q;
    logic        sda_q;

    assign sda_release = !drive_low;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
        drive_low = 1'b0;
        active    = 1'b0;
        sending   = 1'b0;
        go_send   = 1'b0;
        acked     = 1'b0;
        bit_cnt   = 0;
        byte_idx  = 0;
        block     = 3'd0;
        ptr       = 11'd0;
        shreg     = 8'h00;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        forever
        begin
            @(scl or sda);
            if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b0 && sda_q === 1'b1)
            begin
                // start or repeated start
                active    = 1'b1;
                sending   = 1'b0;
                go_send   = 1'b0;
                bit_cnt   = 0;
                byte_idx  = 0;
                drive_low = 1'b0;
            end
            else if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b1 && sda_q === 1'b0)
            begin
                active    = 1'b0;  // stop
                drive_low = 1'b0;
            end
            else if (active && scl === 1'b1 && scl_q === 1'b0)
            begin
                if (bit_cnt < 8 && !sending)
                    shreg = {shreg[6:0], sda};
                if (bit_cnt == 8 && sending)
                    acked = !sda;  // master ack
                bit_cnt++;
            end
            else if (active && scl === 1'b0 && scl_q === 1'b1)
            begin
                if (bit_cnt == 8)
                begin
                    if (sending)
                        drive_low = 1'b0;
                    else
                    begin
                        acked = enable;
                        if (byte_idx == 0)
                        begin
                            acked   = enable && (shreg[7:4] == 4'b1010);
                            block   = shreg[3:1];
                            go_send = shreg[0];
                        end
                        else if (byte_idx == 1)
                            ptr = {block, shreg};
                        else if (enable)
                        begin
                            mem[ptr] = shreg;
                            ptr      = ptr + 11'd1;
                        end
                        drive_low = acked;
                    end
                end
                else if (bit_cnt == 9)
                begin
                    drive_low = 1'b0;
                    bit_cnt   = 0;
                    byte_idx++;
                    if (!acked)
                        active = 1'b0;
                    else if (sending || go_send)
                    begin
                        if (sending)
                            ptr = ptr + 11'd1;
                        sending   = 1'b1;
                        shreg     = mem[ptr];
                        drive_low = !shreg[7];
                    end
                end
                else if (sending && bit_cnt > 0)
                    drive_low = !shreg[7 - bit_cnt];
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

/* tests/tb_eeprom_ctrl.sv */
`timescale 1ns/1ns

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int DONE_TIMEOUT = 60 * 4 * SCL_QUARTER;  // 60 bit periods

    logic         CLK;
    logic         RESET;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    byte_t        wdata;
    byte_t        rdata;
    logic         busy;
    logic         done;
    logic         ack_error;
    logic         scl;
    logic         sda_low;
    logic         sda;
    logic         model_release;
    logic         model_en;

    byte_t        sb [0:2047];
    eeprom_addr_t used [0:19];
    int           errors;
    int           test_errors;
    int           tests;
    int           seed;

    assign sda = !sda_low && model_release;  // released line is pulled up

    eeprom_ctrl_top dut
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .sda_in    (sda),
        .rdata     (rdata),
        .busy      (busy),
        .done      (done),
        .ack_error (ack_error),
        .scl       (scl),
        .sda_low   (sda_low)
    );

    eeprom_model model
    (
        .scl         (scl),
        .sda         (sda),
        .enable      (model_en),
        .sda_release (model_release)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #5 CLK = !CLK;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch at %0t: %s expected %0h actual %0h", $time, name,
                     expected, actual);
            errors++;
        end
    endtask

    task automatic strobe(input logic w, input logic r, input eeprom_addr_t a,
                          input byte_t d);
        wr    = w;
        rd    = r;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_for_done();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < DONE_TIMEOUT && !seen; n++)
        begin
            @(negedge CLK);
            if (done)
                seen = 1'b1;
        end
        if (!seen)
        begin
            $display("timeout at %0t: done did not arrive", $time);
            errors++;
        end
    endtask

    task automatic finish_request();
        wait_for_done();
        @(posedge CLK);
        #1;
    endtask

    task automatic do_write(input eeprom_addr_t a, input byte_t d, input logic exp_err);
        strobe(1'b1, 1'b0, a, d);
        wait_for_done();
        check_value("ack_error", 32'(exp_err), 32'(ack_error));
        @(posedge CLK);
        #1;
    endtask

    task automatic do_read(input eeprom_addr_t a, input byte_t exp, input logic exp_err);
        strobe(1'b0, 1'b1, a, 8'h00);
        wait_for_done();
        check_value("ack_error", 32'(exp_err), 32'(ack_error));
        if (!exp_err)
            check_value("rdata", 32'(exp), 32'(rdata));
        @(posedge CLK);
        #1;
    endtask

    task automatic count_dones(input int cycles, output int n_done);
        n_done = 0;
        for (int n = 0; n < cycles; n++)
        begin
            @(negedge CLK);
            if (done)
                n_done++;
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic report(input string name);
        tests++;
        if (errors == test_errors)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic test_reset_state();
        int n_done;
        @(negedge CLK);
        check_value("scl", 32'd1, 32'(scl));
        check_value("sda_low", 32'd0, 32'(sda_low));
        check_value("busy", 32'd0, 32'(busy));
        check_value("done", 32'd0, 32'(done));
        check_value("ack_error", 32'd0, 32'(ack_error));
        count_dones(50, n_done);
        check_value("done count", 32'd0, 32'(n_done));
        report("reset state");
    endtask

    task automatic test_single();
        sb[11'h123] = 8'h5a;
        do_write(11'h123, 8'h5a, 1'b0);
        do_read(11'h123, sb[11'h123], 1'b0);
        report("write and read back");
    endtask

    task automatic test_random_blocks();
        int    rnd;
        byte_t d;
        for (int i = 0; i < 20; i++)
        begin
            rnd     = $random(seed);
            used[i] = {3'(i % 8), rnd[7:0]};  // every block gets used
            d       = rnd[15:8];
            sb[used[i]] = d;
            do_write(used[i], d, 1'b0);
        end
        for (int i = 19; i >= 0; i--)
            do_read(used[i], sb[used[i]], 1'b0);
        report("random blocks");
    endtask

    task automatic test_absent_device();
        model_en = 1'b0;
        do_write(used[3], ~sb[used[3]], 1'b1);
        do_read(used[3], 8'h00, 1'b1);
        model_en = 1'b1;
        do_read(used[3], sb[used[3]], 1'b0);
        report("absent device");
    endtask

    task automatic test_strobes();
        int n_done;
        sb[11'h7f0] = 8'hc3;
        strobe(1'b1, 1'b0, 11'h7f0, 8'hc3);
        repeat (10) @(posedge CLK);
        #1;
        check_value("busy", 32'd1, 32'(busy));
        strobe(1'b1, 1'b0, used[5], 8'h00);  // ignored
        finish_request();
        count_dones(DONE_TIMEOUT, n_done);  // long enough for a whole request
        check_value("done count", 32'd0, 32'(n_done));
        do_read(used[5], sb[used[5]], 1'b0);
        do_read(11'h7f0, sb[11'h7f0], 1'b0);
        sb[11'h2a1] = 8'h96;
        strobe(1'b1, 1'b1, 11'h2a1, 8'h96);
        finish_request();
        check_value("ack_error", 32'd0, 32'(ack_error));
        do_read(11'h2a1, sb[11'h2a1], 1'b0);
        report("strobe handling");
    endtask

    initial
    begin
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        model_en    = 1'b1;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        seed        = 32'h561e;
        for (int i = 0; i < 2048; i++)
            sb[i] = 8'hff;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;

        test_reset_state();
        test_single();
        test_random_blocks();
        test_absent_device();
        test_strobes();

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* project.f */
common/eeprom_pkg.sv
logic/scl_timer.sv
i2c_master/i2c_byte_engine.sv
i2c_master/eeprom_sequencer.sv
logic/eeprom_ctrl_top.sv
tests/eeprom_model.sv
tests/tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the eeprom controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f project.f --top-module tb_eeprom_ctrl \
    -o sim_tb || { echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q -F '*** PASSED ***' sim.log && echo "simulation ok" \
    || { echo "simulation failed, see sim.log"; exit 1; }
